//--- cholesky_solver.f
+incdir+source
+incdir+verification
source/cholesky_pkg.sv
source/matrix_store.sv
source/fixed_sqrt.sv
source/fixed_divider.sv
source/column_sequencer.sv
source/cholesky_top.sv
verification/cholesky_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the Cholesky testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f cholesky_solver.f --top-module cholesky_tb -Mdir obj_dir

output=$(./obj_dir/Vcholesky_tb)
echo "$output"

if echo "$output" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1

//--- verification/cholesky_model.svh
`ifndef CHOLESKY_MODEL_SVH
`define CHOLESKY_MODEL_SVH

// Element (row, col) with row >= col in the row-major triangle
function automatic int tri_pos(input int row, input int col);
    return row * (row + 1) / 2 + col;
endfunction

// Largest r with r*r <= x, for 0 <= x < 2^48
function automatic longint floor_sqrt(input longint x);
    longint lo;
    longint hi;
    longint mid;
    lo = 0;
    hi = longint'(1) <<< 24;
    while (lo < hi) begin
        mid = (lo + hi + 1) / 2;
        if (mid * mid <= x) begin
            lo = mid;
        end else begin
            hi = mid - 1;
        end
    end
    return lo;
endfunction

// v<<16 over the pivot, truncated toward zero, low word kept
function automatic fixed_t quotient_q16(input fixed_t v, input fixed_t pivot);
    longint num;
    longint q;
    if (pivot == 0) begin
        return '0;
    end
    num = longint'(v) <<< `CHOL_FRAC_W;
    q   = num / longint'(pivot);
    return fixed_t'(q);
endfunction

// Column by column, row by row, products in ascending k
function automatic matrix_flat_t cholesky_ref(input matrix_flat_t a_in);
    matrix_flat_t l_out;
    longint       acc;
    fixed_t       v;
    l_out = '0;
    for (int j = 0; j < `CHOL_N; j++) begin
        for (int i = j; i < `CHOL_N; i++) begin
            acc = longint'(a_in[tri_pos(i, j)]) <<< `CHOL_FRAC_W; // Q32.32
            for (int k = 0; k < j; k++) begin
                acc = acc - longint'(l_out[tri_pos(i, k)]) * longint'(l_out[tri_pos(j, k)]);
            end
            v = fixed_t'(acc >>> `CHOL_FRAC_W);
            if (i != j) begin
                l_out[tri_pos(i, j)] = quotient_q16(v, l_out[tri_pos(j, j)]);
            end else if (v > 0) begin
                l_out[tri_pos(j, j)] = fixed_t'(floor_sqrt(longint'(v) <<< `CHOL_FRAC_W));
            end else begin
                l_out[tri_pos(j, j)] = '0; // Pivot not positive
            end
        end
    end
    return l_out;
endfunction

`endif

//--- verification/cholesky_tb.sv
`timescale 1ns/1ps
`include "cholesky_params.svh"

module cholesky_tb import cholesky_pkg::*; ();

    localparam int NUM_ROWS       = 8;
    localparam int CLK_PERIOD     = 100;
    localparam int CYCLES_PER_ROW = 1600;
    localparam int WATCHDOG_NS    = NUM_ROWS * CYCLES_PER_ROW * CLK_PERIOD;
    localparam int IDLE_HOLD      = 6;    // Idle cycles watched after each result
    localparam int POKE_DELAY     = 20;   // Cycles into a run before the extra strobe

    logic         clk;
    logic         rst;
    logic         a_valid;
    logic         l_valid;
    matrix_flat_t a;
    matrix_flat_t l;

    // Stimulus table
    matrix_flat_t a_tab [NUM_ROWS];
    matrix_flat_t l_tab [NUM_ROWS];
    bit           use_model [NUM_ROWS];   // Expected L taken from the model
    bit           poke_busy [NUM_ROWS];   // Second a_valid while busy

    logic [31:0]  lcg_state;
    int           error_count;
    int           check_count;

    `include "cholesky_model.svh"

    cholesky_top dut (
        .clk     (clk),
        .rst     (rst),
        .a       (a),
        .a_valid (a_valid),
        .l       (l),
        .l_valid (l_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ---------------------------------------------------------------------------
    // Helpers
    // ---------------------------------------------------------------------------
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_result(input int row);
        for (int e = 0; e < `CHOL_TRI_COUNT; e++) begin
            check_value($sformatf("l[%0d]", e), l_tab[row][e], l[e]);
        end
    endtask

    task automatic put_integer_row(input int row, input int a_int [`CHOL_TRI_COUNT],
                                   input int l_int [`CHOL_TRI_COUNT]);
        for (int e = 0; e < `CHOL_TRI_COUNT; e++) begin
            a_tab[row][e] = fixed_t'(a_int[e] <<< `CHOL_FRAC_W);
            l_tab[row][e] = fixed_t'(l_int[e] <<< `CHOL_FRAC_W);
        end
        use_model[row] = 1'b0;
    endtask

    // A = L0*L0^T with a fractional bump on the diagonal
    task automatic fill_random_row(input int row);
        int          l0 [`CHOL_N][`CHOL_N];
        int          sum;
        logic [31:0] r;
        for (int i = 0; i < `CHOL_N; i++) begin
            for (int j = 0; j < `CHOL_N; j++) begin
                r = next_random();
                if (j > i) begin
                    l0[i][j] = 0;
                end else if (j == i) begin
                    l0[i][j] = 1 + int'(r[23:16] % 8'd7);  // Diagonal 1..7
                end else begin
                    l0[i][j] = int'(r[23:16] % 8'd9) - 4;  // -4..4
                end
            end
        end
        for (int i = 0; i < `CHOL_N; i++) begin
            for (int j = 0; j <= i; j++) begin
                sum = 0;
                for (int k = 0; k <= j; k++) begin
                    sum += l0[i][k] * l0[j][k];
                end
                sum = sum <<< `CHOL_FRAC_W;
                if (i == j) begin
                    r   = next_random();
                    sum = sum + int'(r[31:16]);
                end
                a_tab[row][tri_pos(i, j)] = sum;
            end
        end
        l_tab[row]     = cholesky_ref(a_tab[row]);
        use_model[row] = 1'b1;
    endtask

    task automatic build_table();
        for (int r = 0; r < NUM_ROWS; r++) begin
            poke_busy[r] = 1'b0;
        end
        put_integer_row(0, '{1, 0, 1, 0, 0, 1, 0, 0, 0, 1, 0, 0, 0, 0, 1},
                           '{1, 0, 1, 0, 0, 1, 0, 0, 0, 1, 0, 0, 0, 0, 1});
        put_integer_row(1, '{4, 0, 9, 0, 0, 16, 0, 0, 0, 25, 0, 0, 0, 0, 36},
                           '{2, 0, 3, 0, 0, 4, 0, 0, 0, 5, 0, 0, 0, 0, 6});
        put_integer_row(2, '{4, 2, 10, -2, 5, 21, 6, 3, -11, 14, 0, -3, 2, 0, 31},
                           '{2, 1, 3, -1, 2, 4, 3, 0, -2, 1, 0, -1, 1, 2, 5});
        put_integer_row(3, '{1, -2, 5, 0, 3, 13, 1, -3, -3, 11, 2, -4, -6, 5, 15},
                           '{1, -2, 1, 0, 3, 2, 1, -1, 0, 3, 2, 0, -3, 1, 1});
        for (int r = 4; r < NUM_ROWS; r++) begin
            fill_random_row(r);
        end
        poke_busy[3] = 1'b1;
        poke_busy[6] = 1'b1;
    endtask

    task automatic strobe_matrix(input matrix_flat_t value);
        @(posedge clk);
        #1;
        a       = value;
        a_valid = 1'b1;
        @(posedge clk);
        #1;
        a_valid = 1'b0;
        @(negedge clk);
        check_value("l_valid", 32'd0, 32'(l_valid)); // Low once accepted or busy
    endtask

    task automatic apply_row(input int row);
        int cycles;
        strobe_matrix(a_tab[row]);
        if (poke_busy[row]) begin
            repeat (POKE_DELAY) @(posedge clk);
            strobe_matrix(a_tab[0]);                 // Must not restart the run
        end
        cycles = 0;
        while (l_valid !== 1'b1) begin
            @(negedge clk);
            cycles++;
        end
        $display("Row %0d: result after %0d cycles, expected L from %s", row, cycles,
                 use_model[row] ? "model" : "table");
        check_result(row);
        repeat (IDLE_HOLD) begin
            @(negedge clk);
            check_value("l_valid", 32'd1, 32'(l_valid)); // Level held while idle
            check_result(row);
        end
    endtask

    // ---------------------------------------------------------------------------
    // Main sequence
    // ---------------------------------------------------------------------------
    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        a_valid     = 1'b0;
        a           = '0;
        lcg_state   = 32'ha7b6;
        error_count = 0;
        check_count = 0;
        build_table();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_value("l_valid", 32'd0, 32'(l_valid));
        for (int e = 0; e < `CHOL_TRI_COUNT; e++) begin
            check_value($sformatf("l[%0d]", e), 32'd0, l[e]);
        end
        for (int row = 0; row < NUM_ROWS; row++) begin
            apply_row(row);
        end
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("TIMEOUT: l_valid never arrived within %0d ns", WATCHDOG_NS);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- source/cholesky_top.sv
`timescale 1ns/1ps

module cholesky_top import cholesky_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  matrix_flat_t a,
    input  logic         a_valid,
    output matrix_flat_t l,
    output logic         l_valid
);

    logic       load;
    tri_index_t rd_a_index;
    fixed_t     rd_a_data;
    tri_index_t rd_l_index_0;
    fixed_t     rd_l_data_0;
    tri_index_t rd_l_index_1;
    fixed_t     rd_l_data_1;
    logic       wr_en;
    tri_index_t wr_index;
    fixed_t     wr_data;

    matrix_store u_store (
        .clk          (clk),
        .rst          (rst),
        .a            (a),
        .load         (load),
        .rd_a_index   (rd_a_index),
        .rd_a_data    (rd_a_data),
        .rd_l_index_0 (rd_l_index_0),
        .rd_l_data_0  (rd_l_data_0),
        .rd_l_index_1 (rd_l_index_1),
        .rd_l_data_1  (rd_l_data_1),
        .wr_en        (wr_en),
        .wr_index     (wr_index),
        .wr_data      (wr_data),
        .l            (l)
    );

    column_sequencer u_seq (
        .clk          (clk),
        .rst          (rst),
        .a_valid      (a_valid),
        .load         (load),
        .rd_a_index   (rd_a_index),
        .rd_a_data    (rd_a_data),
        .rd_l_index_0 (rd_l_index_0),
        .rd_l_data_0  (rd_l_data_0),
        .rd_l_index_1 (rd_l_index_1),
        .rd_l_data_1  (rd_l_data_1),
        .wr_en        (wr_en),
        .wr_index     (wr_index),
        .wr_data      (wr_data),
        .l_valid      (l_valid)
    );

endmodule

//--- source/column_sequencer.sv
`timescale 1ns/1ps
`include "cholesky_params.svh"

module column_sequencer import cholesky_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       a_valid,

    // Store interface
    output logic       load,
    output tri_index_t rd_a_index,
    input  fixed_t     rd_a_data,
    output tri_index_t rd_l_index_0,
    input  fixed_t     rd_l_data_0,
    output tri_index_t rd_l_index_1,
    input  fixed_t     rd_l_data_1,
    output logic       wr_en,
    output tri_index_t wr_index,
    output fixed_t     wr_data,

    output logic       l_valid
);

    localparam int CNT_W = $clog2(`CHOL_N);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(`CHOL_N - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD,    // Accumulator takes A_ij
        S_ACCUM,   // One product per cycle
        S_SHIFT,   // Start root or divide
        S_ROOT,
        S_DIVIDE,
        S_WRITE
    } state_t;

    state_t           state_q;
    logic [CNT_W-1:0] j_q;     // Column
    logic [CNT_W-1:0] i_q;     // Row
    logic [CNT_W-1:0] k_q;     // Inner product term
    wide_t            acc_q;

    logic   diag;
    wide_t  product;
    fixed_t v;
    wide_t  operand;
    logic   sqrt_start;
    logic   sqrt_done;
    fixed_t sqrt_root;
    logic   div_start;
    logic   div_done;
    fixed_t div_quotient;

    function automatic tri_index_t tri_index(input logic [CNT_W-1:0] row,
                                             input logic [CNT_W-1:0] col);
        logic [7:0] r;
        r = 8'(row);
        return tri_index_t'(((r * (r + 8'd1)) >> 1) + 8'(col));
    endfunction

    // ---------------------------------------------------------------------------
    // Operand fetch and arithmetic
    // ---------------------------------------------------------------------------
    assign rd_a_index   = tri_index(i_q, j_q);
    assign rd_l_index_0 = tri_index(i_q, k_q);
    assign rd_l_index_1 = tri_index(j_q, k_q); // k sits at j once the sum is done

    assign diag    = i_q == j_q;
    assign product = wide_t'(rd_l_data_0) * wide_t'(rd_l_data_1);
    assign v       = fixed_t'(acc_q >>> `CHOL_FRAC_W);
    assign operand = wide_t'(v) <<< `CHOL_FRAC_W;

    assign sqrt_start = (state_q == S_SHIFT) && diag;
    assign div_start  = (state_q == S_SHIFT) && !diag;

    fixed_sqrt u_sqrt (
        .clk      (clk),
        .rst      (rst),
        .start    (sqrt_start),
        .radicand ((v > 0) ? operand : '0), // Non-positive pivot gives 0
        .done     (sqrt_done),
        .root     (sqrt_root)
    );

    fixed_divider u_div (
        .clk      (clk),
        .rst      (rst),
        .start    (div_start),
        .dividend (operand),
        .divisor  (rd_l_data_1),            // L_jj
        .done     (div_done),
        .quotient (div_quotient)
    );

    assign load     = (state_q == S_IDLE) && a_valid; // Busy ignores a_valid
    assign wr_en    = state_q == S_WRITE;
    assign wr_index = tri_index(i_q, j_q);
    assign wr_data  = diag ? sqrt_root : div_quotient;

    // ---------------------------------------------------------------------------
    // Control
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
            j_q     <= '0;
            i_q     <= '0;
            k_q     <= '0;
            l_valid <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (a_valid) begin
                        state_q <= S_LOAD;
                        j_q     <= '0;
                        i_q     <= '0;
                        l_valid <= 1'b0;
                    end
                end
                S_LOAD: begin
                    k_q     <= '0;
                    state_q <= S_ACCUM;
                end
                S_ACCUM: begin
                    if (k_q == j_q) begin
                        state_q <= S_SHIFT;
                    end else begin
                        k_q <= k_q + 1'b1;
                    end
                end
                S_SHIFT:  state_q <= diag ? S_ROOT : S_DIVIDE;
                S_ROOT:   if (sqrt_done) state_q <= S_WRITE;
                S_DIVIDE: if (div_done) state_q <= S_WRITE;
                S_WRITE: begin
                    state_q <= S_LOAD;
                    if (i_q != LAST) begin
                        i_q <= i_q + 1'b1;        // Next row, same column
                    end else if (j_q != LAST) begin
                        j_q <= j_q + 1'b1;
                        i_q <= j_q + 1'b1;        // Column starts at its diagonal
                    end else begin
                        l_valid <= 1'b1;          // Level, held until next accept
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_LOAD) begin
            acc_q <= wide_t'(rd_a_data) <<< `CHOL_FRAC_W;  // A_ij in Q32.32
        end else if (state_q == S_ACCUM && k_q != j_q) begin
            acc_q <= acc_q - product;                      // Minus L_ik*L_jk
        end
    end

endmodule

//--- source/fixed_divider.sv
`timescale 1ns/1ps
`include "cholesky_params.svh"

module fixed_divider import cholesky_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    input  wide_t  dividend,
    input  fixed_t divisor,
    output logic   done,
    output fixed_t quotient
);

    localparam int DIV_W = `CHOL_WORD_W + `CHOL_FRAC_W; // Magnitude of v<<16
    localparam int REM_W = `CHOL_WORD_W;
    localparam int CNT_W = $clog2(DIV_W);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(DIV_W - 1);

    logic             busy_q;
    logic [CNT_W-1:0] count_q;
    logic [DIV_W-1:0] mag_q;   // Dividend magnitude, shifted out from the top
    logic [REM_W-1:0] dvs_q;   // Divisor magnitude
    logic [REM_W-1:0] rem_q;
    logic [DIV_W-1:0] quo_q;
    logic             neg_q;
    logic             zero_q;

    wide_t            dividend_abs;
    logic [REM_W-1:0] divisor_abs;
    logic [REM_W:0]   rem_cat;
    logic             take;
    logic [DIV_W-1:0] quo_next;
    fixed_t           quo_low;

    always_comb begin
        dividend_abs = dividend[`CHOL_WIDE_W-1] ? -dividend : dividend;
        divisor_abs  = divisor[`CHOL_WORD_W-1] ? REM_W'(-divisor) : REM_W'(divisor);
        rem_cat      = {rem_q, mag_q[DIV_W-1]};
        take         = rem_cat >= {1'b0, dvs_q};
        quo_next     = {quo_q[DIV_W-2:0], take};
        quo_low      = fixed_t'(quo_next[`CHOL_WORD_W-1:0]); // Only the low word is kept
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q  <= 1'b0;
            count_q <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy_q  <= 1'b1;
                count_q <= '0;
            end else if (busy_q) begin
                count_q <= count_q + 1'b1;
                if (count_q == LAST) begin
                    busy_q <= 1'b0;
                    done   <= 1'b1; // 49 cycles after start
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mag_q  <= dividend_abs[DIV_W-1:0];
            dvs_q  <= divisor_abs;
            rem_q  <= '0;
            quo_q  <= '0;
            neg_q  <= dividend[`CHOL_WIDE_W-1] ^ divisor[`CHOL_WORD_W-1];
            zero_q <= divisor == '0;
        end else if (busy_q) begin
            mag_q <= mag_q << 1;
            rem_q <= take ? REM_W'(rem_cat - {1'b0, dvs_q}) : rem_cat[REM_W-1:0];
            quo_q <= quo_next;
            if (count_q == LAST) begin
                // Sign applied last, so the result truncates toward zero
                quotient <= zero_q ? '0 : (neg_q ? -quo_low : quo_low);
            end
        end
    end

endmodule

//--- source/fixed_sqrt.sv
`timescale 1ns/1ps
`include "cholesky_params.svh"

module fixed_sqrt import cholesky_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    input  wide_t  radicand,
    output logic   done,
    output fixed_t root
);

    localparam int RAD_W  = `CHOL_WORD_W + `CHOL_FRAC_W; // v<<16 never exceeds 48 bits
    localparam int ROOT_W = RAD_W / 2;                   // One root bit per two radicand bits
    localparam int REM_W  = ROOT_W + 2;
    localparam int CNT_W  = $clog2(ROOT_W);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(ROOT_W - 1);

    logic              busy_q;
    logic [CNT_W-1:0]  count_q;
    logic [RAD_W-1:0]  rad_q;   // Radicand, consumed from the top two bits at a time
    logic [REM_W-1:0]  rem_q;
    logic [ROOT_W-1:0] root_q;

    logic [REM_W+1:0]  rem_cat;
    logic [REM_W+1:0]  trial;
    logic              take;
    logic [ROOT_W-1:0] root_next;

    always_comb begin
        rem_cat   = {rem_q, rad_q[RAD_W-1 -: 2]}; // Bring down the next bit pair
        trial     = {2'b00, root_q, 2'b01};       // 4*root + 1
        take      = rem_cat >= trial;
        root_next = {root_q[ROOT_W-2:0], take};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q  <= 1'b0;
            count_q <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy_q  <= 1'b1;
                count_q <= '0;
            end else if (busy_q) begin
                count_q <= count_q + 1'b1;
                if (count_q == LAST) begin
                    busy_q <= 1'b0;
                    done   <= 1'b1; // 25 cycles after start
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rad_q  <= radicand[RAD_W-1:0];
            rem_q  <= '0;
            root_q <= '0;
        end else if (busy_q) begin
            rad_q  <= rad_q << 2;
            rem_q  <= take ? REM_W'(rem_cat - trial) : rem_cat[REM_W-1:0];
            root_q <= root_next;
            if (count_q == LAST) begin
                root <= fixed_t'(root_next); // Floor root, held until the next result
            end
        end
    end

endmodule

//--- source/matrix_store.sv
`timescale 1ns/1ps
`include "cholesky_params.svh"

module matrix_store import cholesky_pkg::*; (
    input  logic         clk,
    input  logic         rst,

    // Capture of A
    input  matrix_flat_t a,
    input  logic         load,

    // A read port
    input  tri_index_t   rd_a_index,
    output fixed_t       rd_a_data,

    // Two L read ports for the inner product
    input  tri_index_t   rd_l_index_0,
    output fixed_t       rd_l_data_0,
    input  tri_index_t   rd_l_index_1,
    output fixed_t       rd_l_data_1,

    // L write port
    input  logic         wr_en,
    input  tri_index_t   wr_index,
    input  fixed_t       wr_data,

    // Whole L triangle
    output matrix_flat_t l
);

    fixed_t a_mem [`CHOL_TRI_COUNT]; // Captured input triangle
    fixed_t l_mem [`CHOL_TRI_COUNT]; // Factor under construction

    // ---------------------------------------------------------------------------
    // Storage
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (load) begin
            for (int e = 0; e < `CHOL_TRI_COUNT; e++) begin
                a_mem[e] <= fixed_t'(a[e]); // Whole triangle in one cycle
            end
        end
    end

    // L is visible at the top, so it starts from zero
    always_ff @(posedge clk) begin
        if (rst || load) begin
            for (int e = 0; e < `CHOL_TRI_COUNT; e++) begin
                l_mem[e] <= '0;
            end
        end else if (wr_en) begin
            l_mem[wr_index] <= wr_data; // One element per writeback
        end
    end

    // ---------------------------------------------------------------------------
    // Read ports
    // ---------------------------------------------------------------------------
    assign rd_a_data   = a_mem[rd_a_index];
    assign rd_l_data_0 = l_mem[rd_l_index_0]; // L_ik
    assign rd_l_data_1 = l_mem[rd_l_index_1]; // L_jk, or L_jj when k reaches j

    always_comb begin
        for (int e = 0; e < `CHOL_TRI_COUNT; e++) begin
            l[e] = l_mem[e]; // Same packing as the input
        end
    end

endmodule

//--- source/cholesky_pkg.sv
`include "cholesky_params.svh"

package cholesky_pkg;

    // One matrix element, signed Q16.16
    typedef logic signed [`CHOL_WORD_W-1:0] fixed_t;

    // Accumulator for inner products, signed Q32.32
    typedef logic signed [`CHOL_WIDE_W-1:0] wide_t;

    // Position of (i,j) in the packed triangle: i*(i+1)/2 + j
    typedef logic [$clog2(`CHOL_TRI_COUNT)-1:0] tri_index_t;

    // Whole lower triangle, row-major, element 0 in the lowest bits
    typedef fixed_t [`CHOL_TRI_COUNT-1:0] matrix_flat_t;

endpackage

//--- source/cholesky_params.svh
`ifndef CHOLESKY_PARAMS_SVH
`define CHOLESKY_PARAMS_SVH

// ---------------------------------------------------------------------------
// Matrix geometry
// ---------------------------------------------------------------------------
`define CHOL_N          5     // Matrix order
`define CHOL_TRI_COUNT  15    // Lower triangle words, N*(N+1)/2

// ---------------------------------------------------------------------------
// Number format
// ---------------------------------------------------------------------------
`define CHOL_WORD_W     32    // Signed Q16.16 element
`define CHOL_FRAC_W     16    // Fraction bits of one element
`define CHOL_WIDE_W     64    // Q32.32 accumulator, holds a full product

`endif
